//--- hw/cpu_pkg.sv
package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [3:0]  byte_en_t;

  // first fetch address out of reset
  localparam word_t    RESET_PC = 32'hbfc00000;
  // jal writes its return address here
  localparam reg_idx_t LINK_REG = 5'd31;
  localparam int       NUM_REGS = 32;

  // primary opcode, inst[31:26]
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_J       = 6'h02,
    OP_JAL     = 6'h03,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_ADDIU   = 6'h09,
    OP_ANDI    = 6'h0c,
    OP_ORI     = 6'h0d,
    OP_LUI     = 6'h0f,
    OP_LB      = 6'h20,
    OP_LW      = 6'h23,
    OP_LBU     = 6'h24,
    OP_SB      = 6'h28,
    OP_SW      = 6'h2b
  } opcode_e;

  // function field of SPECIAL, inst[5:0]
  typedef enum logic [5:0] {
    FN_SLL  = 6'h00,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_SLT  = 6'h2a,
    FN_SLTU = 6'h2b
  } funct_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_LUI, ALU_LINK
  } alu_op_e;

  typedef enum logic [2:0] {
    MEM_NONE, MEM_LW, MEM_LB, MEM_LBU, MEM_SW, MEM_SB
  } mem_op_e;

endpackage

//--- hw/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
  input  logic           clk,
  input  logic           arst_n_i,
  input  logic           bus_stall_i,
  input  logic           load_use_i,
  input  logic           branch_taken_i,
  input  cpu_pkg::word_t branch_target_i,
  input  cpu_pkg::word_t inst_sram_rdata_i,
  output logic           inst_sram_en_o,
  output cpu_pkg::word_t inst_sram_addr_o,
  output cpu_pkg::word_t id_pc_o,
  output cpu_pkg::word_t id_inst_o
);
  import cpu_pkg::*;

  word_t pc_q;
  logic  valid_q;
  logic  redir_q;
  word_t redir_pc_q;
  logic  hold;
  word_t fetch_pc;

  assign hold = bus_stall_i | load_use_i;

  // a held decode slot refetches its own address, so the sram data repeats
  always_comb begin
    if (hold && valid_q) begin
      fetch_pc = pc_q;
    end else if (redir_q) begin
      fetch_pc = redir_pc_q;
    end else begin
      fetch_pc = pc_q + 32'd4;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q    <= RESET_PC - 32'd4;
      valid_q <= 1'b0;
      redir_q <= 1'b0;
    end else if (!hold) begin
      pc_q    <= fetch_pc;
      valid_q <= 1'b1;
      redir_q <= branch_taken_i;
    end
  end

  // target is issued after the delay slot
  always_ff @(posedge clk) begin
    if (!hold) begin
      redir_pc_q <= branch_target_i;
    end
  end

  assign inst_sram_en_o   = 1'b1;
  assign inst_sram_addr_o = fetch_pc;
  assign id_pc_o          = pc_q;
  // all zero is sll $0, i.e. a nop
  assign id_inst_o        = valid_q ? inst_sram_rdata_i : '0;

endmodule

//--- hw/decoder.sv
`timescale 1ns/1ps

module decoder (
  input  cpu_pkg::word_t    id_pc_i,
  input  cpu_pkg::word_t    id_inst_i,
  input  cpu_pkg::word_t    rs_data_i,
  input  cpu_pkg::word_t    rt_data_i,
  input  logic              ex_load_i,
  input  logic              mem_load_i,
  input  cpu_pkg::reg_idx_t ex_dest_i,
  input  cpu_pkg::reg_idx_t mem_dest_i,
  output cpu_pkg::reg_idx_t rs_addr_o,
  output cpu_pkg::reg_idx_t rt_addr_o,
  output cpu_pkg::alu_op_e  alu_op_o,
  output cpu_pkg::mem_op_e  mem_op_o,
  output cpu_pkg::word_t    op_a_o,
  output cpu_pkg::word_t    op_b_o,
  output cpu_pkg::word_t    store_data_o,
  output cpu_pkg::reg_idx_t dest_o,
  output logic              wreg_o,
  output logic              branch_taken_o,
  output cpu_pkg::word_t    branch_target_o,
  output logic              load_use_o
);
  import cpu_pkg::*;

  opcode_e  opcode;
  funct_e   funct;
  word_t    simm;
  word_t    zimm;
  word_t    pc_plus4;
  logic     reads_rs;
  logic     reads_rt;
  logic     branch;
  logic     wreg;
  logic     rs_hit;
  logic     rt_hit;

  assign opcode   = opcode_e'(id_inst_i[31:26]);
  assign funct    = funct_e'(id_inst_i[5:0]);
  assign simm     = {{16{id_inst_i[15]}}, id_inst_i[15:0]};
  assign zimm     = {16'h0000, id_inst_i[15:0]};
  assign pc_plus4 = id_pc_i + 32'd4;

  assign rs_addr_o    = id_inst_i[25:21];
  assign rt_addr_o    = id_inst_i[20:16];
  assign store_data_o = rt_data_i;

  always_comb begin
    alu_op_o        = ALU_ADD;
    mem_op_o        = MEM_NONE;
    op_a_o          = rs_data_i;
    op_b_o          = rt_data_i;
    dest_o          = id_inst_i[15:11];
    wreg            = 1'b0;
    reads_rs        = 1'b0;
    reads_rt        = 1'b0;
    branch          = 1'b0;
    branch_target_o = pc_plus4 + {simm[29:0], 2'b00};
    case (opcode)
      OP_SPECIAL: begin
        wreg     = 1'b1;
        reads_rs = 1'b1;
        reads_rt = 1'b1;
        case (funct)
          FN_ADDU: alu_op_o = ALU_ADD;
          FN_SUBU: alu_op_o = ALU_SUB;
          FN_AND:  alu_op_o = ALU_AND;
          FN_OR:   alu_op_o = ALU_OR;
          FN_XOR:  alu_op_o = ALU_XOR;
          FN_SLT:  alu_op_o = ALU_SLT;
          FN_SLTU: alu_op_o = ALU_SLTU;
          FN_SLL: begin
            alu_op_o = ALU_SLL;
            op_a_o   = {27'd0, id_inst_i[10:6]};
            reads_rs = 1'b0;
          end
          default: wreg = 1'b0;
        endcase
      end
      OP_ADDIU, OP_ANDI, OP_ORI, OP_LUI, OP_LW, OP_LB, OP_LBU: begin
        dest_o   = rt_addr_o;
        wreg     = 1'b1;
        reads_rs = (opcode != OP_LUI);
        op_b_o   = simm;
        case (opcode)
          OP_ANDI: begin
            alu_op_o = ALU_AND;
            op_b_o   = zimm;
          end
          OP_ORI: begin
            alu_op_o = ALU_OR;
            op_b_o   = zimm;
          end
          OP_LUI:  alu_op_o = ALU_LUI;
          OP_LW:   mem_op_o = MEM_LW;
          OP_LB:   mem_op_o = MEM_LB;
          OP_LBU:  mem_op_o = MEM_LBU;
          default: alu_op_o = ALU_ADD;
        endcase
      end
      OP_SW, OP_SB: begin
        op_b_o   = simm;
        reads_rs = 1'b1;
        reads_rt = 1'b1;
        mem_op_o = (opcode == OP_SW) ? MEM_SW : MEM_SB;
      end
      OP_BEQ, OP_BNE: begin
        reads_rs = 1'b1;
        reads_rt = 1'b1;
        branch   = (rs_data_i == rt_data_i) ^ (opcode == OP_BNE);
      end
      OP_J, OP_JAL: begin
        branch          = 1'b1;
        branch_target_o = {pc_plus4[31:28], id_inst_i[25:0], 2'b00};
        // link value skips the delay slot
        alu_op_o        = ALU_LINK;
        op_a_o          = id_pc_i + 32'd8;
        dest_o          = LINK_REG;
        wreg            = (opcode == OP_JAL);
      end
      default: wreg = 1'b0;
    endcase
  end

  // writes to $0 are dropped here
  assign wreg_o = wreg && (dest_o != '0);

  // load results are not forwardable before writeback
  assign rs_hit = (ex_load_i && ex_dest_i == rs_addr_o) || (mem_load_i && mem_dest_i == rs_addr_o);
  assign rt_hit = (ex_load_i && ex_dest_i == rt_addr_o) || (mem_load_i && mem_dest_i == rt_addr_o);

  assign load_use_o     = (reads_rs && rs_hit) || (reads_rt && rt_hit);
  assign branch_taken_o = branch && !load_use_o;

endmodule

//--- hw/regfile.sv
`timescale 1ns/1ps

module regfile (
  input  logic              clk,
  input  logic              arst_n_i,
  input  cpu_pkg::reg_idx_t rs_addr_i,
  input  cpu_pkg::reg_idx_t rt_addr_i,
  output cpu_pkg::word_t    rs_data_o,
  output cpu_pkg::word_t    rt_data_o,
  input  logic              ex_we_i,
  input  logic              mem_we_i,
  input  logic              wb_we_i,
  input  cpu_pkg::reg_idx_t ex_dest_i,
  input  cpu_pkg::reg_idx_t mem_dest_i,
  input  cpu_pkg::reg_idx_t wb_dest_i,
  input  cpu_pkg::word_t    ex_data_i,
  input  cpu_pkg::word_t    mem_data_i,
  input  cpu_pkg::word_t    wb_data_i
);
  import cpu_pkg::*;

  // $0 has no storage
  word_t regs [1:NUM_REGS-1];

  // youngest producer wins
  function automatic word_t read_port(input reg_idx_t addr);
    if (addr == '0) begin
      return '0;
    end else if (ex_we_i && ex_dest_i == addr) begin
      return ex_data_i;
    end else if (mem_we_i && mem_dest_i == addr) begin
      return mem_data_i;
    end else if (wb_we_i && wb_dest_i == addr) begin
      return wb_data_i;
    end
    return regs[addr];
  endfunction

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_we_i && wb_dest_i != '0) begin
      regs[wb_dest_i] <= wb_data_i;
    end
  end

  always_comb begin
    rs_data_o = read_port(rs_addr_i);
    rt_data_o = read_port(rt_addr_i);
  end

endmodule

//--- hw/execute.sv
`timescale 1ns/1ps

module execute (
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              bus_stall_i,
  input  logic              load_use_i,
  input  cpu_pkg::alu_op_e  alu_op_i,
  input  cpu_pkg::mem_op_e  mem_op_i,
  input  cpu_pkg::word_t    op_a_i,
  input  cpu_pkg::word_t    op_b_i,
  input  cpu_pkg::word_t    store_data_i,
  input  cpu_pkg::reg_idx_t dest_i,
  input  logic              wreg_i,
  input  cpu_pkg::word_t    pc_i,
  output logic              ex_wreg_o,
  output cpu_pkg::reg_idx_t ex_dest_o,
  output cpu_pkg::word_t    ex_result_o,
  output cpu_pkg::mem_op_e  ex_mem_op_o,
  output cpu_pkg::word_t    ex_store_data_o,
  output cpu_pkg::word_t    ex_pc_o,
  output logic              ex_load_o
);
  import cpu_pkg::*;

  alu_op_e alu_op_q;
  word_t   op_a_q;
  word_t   op_b_q;

  // interlocked instruction stays in decode, a bubble moves on
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ex_wreg_o   <= 1'b0;
      ex_mem_op_o <= MEM_NONE;
    end else if (!bus_stall_i) begin
      ex_wreg_o   <= wreg_i && !load_use_i;
      ex_mem_op_o <= load_use_i ? MEM_NONE : mem_op_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!bus_stall_i) begin
      alu_op_q        <= alu_op_i;
      op_a_q          <= op_a_i;
      op_b_q          <= op_b_i;
      ex_store_data_o <= store_data_i;
      ex_dest_o       <= dest_i;
      ex_pc_o         <= pc_i;
    end
  end

  always_comb begin
    case (alu_op_q)
      ALU_ADD:  ex_result_o = op_a_q + op_b_q;
      ALU_SUB:  ex_result_o = op_a_q - op_b_q;
      ALU_AND:  ex_result_o = op_a_q & op_b_q;
      ALU_OR:   ex_result_o = op_a_q | op_b_q;
      ALU_XOR:  ex_result_o = op_a_q ^ op_b_q;
      ALU_SLT:  ex_result_o = {31'd0, $signed(op_a_q) < $signed(op_b_q)};
      ALU_SLTU: ex_result_o = {31'd0, op_a_q < op_b_q};
      ALU_SLL:  ex_result_o = op_b_q << op_a_q[4:0];
      ALU_LUI:  ex_result_o = {op_b_q[15:0], 16'h0000};
      ALU_LINK: ex_result_o = op_a_q;
      default:  ex_result_o = '0;
    endcase
  end

  assign ex_load_o = ex_wreg_o && (ex_mem_op_o inside {MEM_LW, MEM_LB, MEM_LBU});

endmodule

//--- hw/mem_access.sv
`timescale 1ns/1ps

module mem_access (
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              bus_stall_i,
  input  logic              ex_wreg_i,
  input  cpu_pkg::reg_idx_t ex_dest_i,
  input  cpu_pkg::word_t    ex_result_i,
  input  cpu_pkg::mem_op_e  ex_mem_op_i,
  input  cpu_pkg::word_t    ex_store_data_i,
  input  cpu_pkg::word_t    ex_pc_i,
  input  logic              ex_load_i,
  output logic              data_sram_en_o,
  output cpu_pkg::byte_en_t data_sram_wen_o,
  output cpu_pkg::word_t    data_sram_addr_o,
  output cpu_pkg::word_t    data_sram_wdata_o,
  input  cpu_pkg::word_t    data_sram_rdata_i,
  output logic              mem_we_o,
  output cpu_pkg::reg_idx_t mem_dest_o,
  output cpu_pkg::word_t    mem_data_o,
  output logic              mem_load_o,
  output logic              wb_we_o,
  output cpu_pkg::reg_idx_t wb_dest_o,
  output cpu_pkg::word_t    wb_data_o,
  output cpu_pkg::word_t    wb_pc_o
);
  import cpu_pkg::*;

  logic    m_wreg_q;
  mem_op_e m_mem_op_q;
  word_t   m_store_q;
  word_t   m_pc_q;
  mem_op_e w_mem_op_q;
  word_t   w_result_q;
  logic    stall_q;
  word_t   rdata_q;
  word_t   rdata;
  logic [7:0] lane_byte;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      m_wreg_q   <= 1'b0;
      mem_load_o <= 1'b0;
      m_mem_op_q <= MEM_NONE;
      wb_we_o    <= 1'b0;
      w_mem_op_q <= MEM_NONE;
      stall_q    <= 1'b0;
    end else begin
      stall_q <= bus_stall_i;
      if (!bus_stall_i) begin
        m_wreg_q   <= ex_wreg_i;
        mem_load_o <= ex_load_i;
        m_mem_op_q <= ex_mem_op_i;
        wb_we_o    <= m_wreg_q;
        w_mem_op_q <= m_mem_op_q;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!bus_stall_i) begin
      mem_dest_o <= ex_dest_i;
      mem_data_o <= ex_result_i;
      m_store_q  <= ex_store_data_i;
      m_pc_q     <= ex_pc_i;
      wb_dest_o  <= mem_dest_o;
      w_result_q <= mem_data_o;
      wb_pc_o    <= m_pc_q;
    end
    // the sram answers the memory stage during a freeze, keep the first reply
    if (!stall_q) begin
      rdata_q <= data_sram_rdata_i;
    end
  end

  // address still sits in the forwarding data while a load is in memory
  assign mem_we_o = m_wreg_q && !mem_load_o;

  assign data_sram_en_o   = (m_mem_op_q != MEM_NONE);
  assign data_sram_addr_o = mem_data_o;

  always_comb begin
    data_sram_wen_o   = 4'b0000;
    data_sram_wdata_o = m_store_q;
    case (m_mem_op_q)
      MEM_SW: data_sram_wen_o = 4'b1111;
      MEM_SB: begin
        data_sram_wen_o   = 4'b0001 << mem_data_o[1:0];
        data_sram_wdata_o = {4{m_store_q[7:0]}};
      end
      default: data_sram_wen_o = 4'b0000;
    endcase
  end

  assign rdata     = stall_q ? rdata_q : data_sram_rdata_i;
  assign lane_byte = rdata[8*w_result_q[1:0] +: 8];

  always_comb begin
    case (w_mem_op_q)
      MEM_LW:  wb_data_o = rdata;
      MEM_LB:  wb_data_o = {{24{lane_byte[7]}}, lane_byte};
      MEM_LBU: wb_data_o = {24'd0, lane_byte};
      default: wb_data_o = w_result_q;
    endcase
  end

endmodule

//--- hw/cpu_core.sv
`timescale 1ns/1ps

module cpu_core (
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              bus_stall_i,
  output logic              inst_sram_en_o,
  output cpu_pkg::word_t    inst_sram_addr_o,
  input  cpu_pkg::word_t    inst_sram_rdata_i,
  output logic              data_sram_en_o,
  output cpu_pkg::byte_en_t data_sram_wen_o,
  output cpu_pkg::word_t    data_sram_addr_o,
  output cpu_pkg::word_t    data_sram_wdata_o,
  input  cpu_pkg::word_t    data_sram_rdata_i,
  output cpu_pkg::word_t    debug_wb_pc_o,
  output cpu_pkg::byte_en_t debug_wb_rf_wen_o,
  output cpu_pkg::reg_idx_t debug_wb_rf_wnum_o,
  output cpu_pkg::word_t    debug_wb_rf_wdata_o
);
  import cpu_pkg::*;

  // fetch and decode
  word_t    id_pc, id_inst, branch_target;
  logic     branch_taken, load_use;
  reg_idx_t rs_addr, rt_addr;
  word_t    rs_data, rt_data;
  alu_op_e  id_alu_op;
  mem_op_e  id_mem_op;
  word_t    id_op_a, id_op_b, id_store_data;
  reg_idx_t id_dest;
  logic     id_wreg;

  // execute, memory, writeback
  logic     ex_wreg, ex_load, mem_we, mem_load, wb_we;
  reg_idx_t ex_dest, mem_dest, wb_dest;
  word_t    ex_result, ex_store_data, ex_pc, mem_data, wb_data;
  mem_op_e  ex_mem_op;

  fetch_unit u_fetch_unit (
    .clk(clk), .arst_n_i(arst_n_i), .bus_stall_i(bus_stall_i), .load_use_i(load_use),
    .branch_taken_i(branch_taken), .branch_target_i(branch_target),
    .inst_sram_rdata_i(inst_sram_rdata_i), .inst_sram_en_o(inst_sram_en_o),
    .inst_sram_addr_o(inst_sram_addr_o), .id_pc_o(id_pc), .id_inst_o(id_inst)
  );

  decoder u_decoder (
    .id_pc_i(id_pc), .id_inst_i(id_inst), .rs_data_i(rs_data), .rt_data_i(rt_data),
    .ex_load_i(ex_load), .mem_load_i(mem_load), .ex_dest_i(ex_dest), .mem_dest_i(mem_dest),
    .rs_addr_o(rs_addr), .rt_addr_o(rt_addr), .alu_op_o(id_alu_op), .mem_op_o(id_mem_op),
    .op_a_o(id_op_a), .op_b_o(id_op_b), .store_data_o(id_store_data),
    .dest_o(id_dest), .wreg_o(id_wreg), .branch_taken_o(branch_taken),
    .branch_target_o(branch_target), .load_use_o(load_use)
  );

  regfile u_regfile (
    .clk(clk), .arst_n_i(arst_n_i),
    .rs_addr_i(rs_addr), .rt_addr_i(rt_addr), .rs_data_o(rs_data), .rt_data_o(rt_data),
    .ex_we_i(ex_wreg), .mem_we_i(mem_we), .wb_we_i(wb_we),
    .ex_dest_i(ex_dest), .mem_dest_i(mem_dest), .wb_dest_i(wb_dest),
    .ex_data_i(ex_result), .mem_data_i(mem_data), .wb_data_i(wb_data)
  );

  execute u_execute (
    .clk(clk), .arst_n_i(arst_n_i), .bus_stall_i(bus_stall_i), .load_use_i(load_use),
    .alu_op_i(id_alu_op), .mem_op_i(id_mem_op), .op_a_i(id_op_a), .op_b_i(id_op_b),
    .store_data_i(id_store_data), .dest_i(id_dest), .wreg_i(id_wreg), .pc_i(id_pc),
    .ex_wreg_o(ex_wreg), .ex_dest_o(ex_dest), .ex_result_o(ex_result),
    .ex_mem_op_o(ex_mem_op), .ex_store_data_o(ex_store_data), .ex_pc_o(ex_pc),
    .ex_load_o(ex_load)
  );

  mem_access u_mem_access (
    .clk(clk), .arst_n_i(arst_n_i), .bus_stall_i(bus_stall_i),
    .ex_wreg_i(ex_wreg), .ex_dest_i(ex_dest), .ex_result_i(ex_result),
    .ex_mem_op_i(ex_mem_op), .ex_store_data_i(ex_store_data), .ex_pc_i(ex_pc),
    .ex_load_i(ex_load), .data_sram_en_o(data_sram_en_o), .data_sram_wen_o(data_sram_wen_o),
    .data_sram_addr_o(data_sram_addr_o), .data_sram_wdata_o(data_sram_wdata_o),
    .data_sram_rdata_i(data_sram_rdata_i),
    .mem_we_o(mem_we), .mem_dest_o(mem_dest), .mem_data_o(mem_data), .mem_load_o(mem_load),
    .wb_we_o(wb_we), .wb_dest_o(wb_dest), .wb_data_o(wb_data), .wb_pc_o(debug_wb_pc_o)
  );

  // trace shows the retiring register write
  assign debug_wb_rf_wen_o   = {4{wb_we}};
  assign debug_wb_rf_wnum_o  = wb_dest;
  assign debug_wb_rf_wdata_o = wb_data;

endmodule

//--- verif/tb_sram_model.sv
`timescale 1ns/1ps

module tb_sram_model (
  input  logic              clk,
  input  logic              en_i,
  input  cpu_pkg::byte_en_t wen_i,
  input  cpu_pkg::word_t    addr_i,
  input  cpu_pkg::word_t    wdata_i,
  output cpu_pkg::word_t    rdata_o
);
  import cpu_pkg::*;

  word_t mem [0:1023];

  initial begin
    rdata_o = '0;
  end

  // one cycle read latency, read returns the old word on a write
  always @(posedge clk) begin
    if (en_i) begin
      rdata_o <= mem[addr_i[11:2]];
      for (int i = 0; i < 4; i++) begin
        if (wen_i[i]) begin
          mem[addr_i[11:2]][8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
    end
  end

  // zero fill, or a pattern mixing the whole byte address
  task automatic fill(input logic use_pattern);
    word_t a;
    for (int i = 0; i < 1024; i++) begin
      a = word_t'(i) << 2;
      mem[i] = use_pattern ? ((a * 32'h9e3779b1) ^ {a[15:0], a[31:16]}) : '0;
    end
  endtask

  task automatic load_word(input word_t addr, input word_t data);
    mem[addr[11:2]] = data;
  endtask

  function automatic word_t peek(input word_t addr);
    return mem[addr[11:2]];
  endfunction

endmodule

//--- verif/tb_cpu_core.sv
`timescale 1ns/1ps

module tb_cpu_core;
  import cpu_pkg::*;

  // nine runs of at most 40 instructions, tripled under stalls, plus reset and margin
  localparam int MAX_CYCLES = 4000;
  localparam int TEST_CYCLES = 300;

  logic     clk;
  logic     arst_n_i;
  logic     bus_stall_i;
  logic     stall_on;
  logic     inst_en, data_en;
  word_t    inst_addr, inst_rdata, data_addr, data_wdata, data_rdata;
  byte_en_t data_wen, dbg_wen;
  word_t    dbg_pc, dbg_wdata;
  reg_idx_t dbg_wnum;

  word_t    prog[$];
  word_t    exp_pc[$], exp_data[$], got_pc[$], got_data[$];
  reg_idx_t exp_num[$], got_num[$];
  word_t    exp_st_addr[$], exp_st_data[$], got_st_addr[$], got_st_data[$];
  byte_en_t exp_st_wen[$], got_st_wen[$];
  word_t    ref_mem[word_t];
  int       errors, tests, failing, cycles;

  cpu_core i_cpu_core (
    .clk(clk), .arst_n_i(arst_n_i), .bus_stall_i(bus_stall_i),
    .inst_sram_en_o(inst_en), .inst_sram_addr_o(inst_addr), .inst_sram_rdata_i(inst_rdata),
    .data_sram_en_o(data_en), .data_sram_wen_o(data_wen), .data_sram_addr_o(data_addr),
    .data_sram_wdata_o(data_wdata), .data_sram_rdata_i(data_rdata),
    .debug_wb_pc_o(dbg_pc), .debug_wb_rf_wen_o(dbg_wen),
    .debug_wb_rf_wnum_o(dbg_wnum), .debug_wb_rf_wdata_o(dbg_wdata)
  );

  tb_sram_model i_inst_mem (
    .clk(clk), .en_i(inst_en), .wen_i(4'b0000), .addr_i(inst_addr),
    .wdata_i('0), .rdata_o(inst_rdata)
  );

  tb_sram_model i_data_mem (
    .clk(clk), .en_i(data_en), .wen_i(data_wen), .addr_i(data_addr),
    .wdata_i(data_wdata), .rdata_o(data_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("** Error @%0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      $display("** Error @%0t: %s got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_wen(input string name, input byte_en_t got, input byte_en_t exp);
    if (got !== exp) begin
      $display("** Error @%0t: %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  // random freeze, driven just after the edge
  always @(posedge clk) begin
    #1;
    bus_stall_i = stall_on ? ($urandom % 4 == 0) : 1'b0;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("run stopped, cycle limit of %0d reached", MAX_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  // a trace entry counts on the cycle it leaves writeback
  always @(negedge clk) begin
    if (arst_n_i && !bus_stall_i && dbg_wen != '0) begin
      check_wen("debug_wb_rf_wen_o", dbg_wen, 4'hf);
      got_pc.push_back(dbg_pc);
      got_num.push_back(dbg_wnum);
      got_data.push_back(dbg_wdata);
    end
    // a store counts on the cycle it leaves the memory stage
    if (arst_n_i && !bus_stall_i && data_wen != '0) begin
      check_word("data_sram_en_o", {31'd0, data_en}, 32'd1);
      got_st_addr.push_back(data_addr);
      got_st_wen.push_back(data_wen);
      got_st_data.push_back(data_wdata);
    end
  end

  function automatic word_t encode_r(funct_e fn, int rs, int rt, int rd, int sh);
    return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
  endfunction

  function automatic word_t encode_i(opcode_e op, int rs, int rt, int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  function automatic word_t encode_j(opcode_e op, int idx);
    word_t target;
    target = RESET_PC + 4 * idx;
    return {op, target[27:2]};
  endfunction

  function automatic word_t ref_read(input word_t a);
    if (ref_mem.exists(a)) begin
      return ref_mem[a];
    end
    return i_data_mem.peek(a);
  endfunction

  // sequential MIPS semantics, the delay slot runs before the target
  task automatic build_expected();
    word_t r[32];
    word_t pc, npc, tgt, inst, a, v, w, simm;
    logic [7:0] lane;
    logic taken, wr;
    reg_idx_t d;
    foreach (r[i]) r[i] = '0;
    exp_pc.delete();
    exp_num.delete();
    exp_data.delete();
    exp_st_addr.delete();
    exp_st_wen.delete();
    exp_st_data.delete();
    ref_mem.delete();
    pc = RESET_PC;
    npc = pc + 4;
    while (((pc - RESET_PC) >> 2) < prog.size()) begin
      inst = prog[(pc - RESET_PC) >> 2];
      simm = {{16{inst[15]}}, inst[15:0]};
      a = r[inst[25:21]] + simm;
      w = ref_read({a[31:2], 2'b00});
      lane = w[8*a[1:0] +: 8];
      wr = 1'b1;
      taken = 1'b0;
      d = inst[20:16];
      v = '0;
      tgt = pc + 4 + (simm << 2);
      case (opcode_e'(inst[31:26]))
        OP_SPECIAL: begin
          d = inst[15:11];
          case (funct_e'(inst[5:0]))
            FN_ADDU: v = r[inst[25:21]] + r[inst[20:16]];
            FN_SUBU: v = r[inst[25:21]] - r[inst[20:16]];
            FN_AND:  v = r[inst[25:21]] & r[inst[20:16]];
            FN_OR:   v = r[inst[25:21]] | r[inst[20:16]];
            FN_XOR:  v = r[inst[25:21]] ^ r[inst[20:16]];
            FN_SLT:  v = ($signed(r[inst[25:21]]) < $signed(r[inst[20:16]])) ? 1 : 0;
            FN_SLTU: v = (r[inst[25:21]] < r[inst[20:16]]) ? 1 : 0;
            FN_SLL:  v = r[inst[20:16]] << inst[10:6];
            default: wr = 1'b0;
          endcase
        end
        OP_ADDIU: v = a;
        OP_ANDI:  v = r[inst[25:21]] & {16'h0000, inst[15:0]};
        OP_ORI:   v = r[inst[25:21]] | {16'h0000, inst[15:0]};
        OP_LUI:   v = {inst[15:0], 16'h0000};
        OP_LW:    v = w;
        OP_LB:    v = {{24{lane[7]}}, lane};
        OP_LBU:   v = {24'd0, lane};
        OP_SW: begin
          wr = 1'b0;
          ref_mem[{a[31:2], 2'b00}] = r[inst[20:16]];
          exp_st_addr.push_back(a);
          exp_st_wen.push_back(4'hf);
          exp_st_data.push_back(r[inst[20:16]]);
        end
        OP_SB: begin
          wr = 1'b0;
          w[8*a[1:0] +: 8] = r[inst[20:16]][7:0];
          ref_mem[{a[31:2], 2'b00}] = w;
          // byte goes out on every lane, one strobe set
          exp_st_addr.push_back(a);
          exp_st_wen.push_back(byte_en_t'(4'b0001 << a[1:0]));
          exp_st_data.push_back({4{r[inst[20:16]][7:0]}});
        end
        OP_BEQ, OP_BNE: begin
          wr = 1'b0;
          taken = (r[inst[25:21]] == r[inst[20:16]]) ^ (inst[31:26] == OP_BNE);
        end
        OP_J, OP_JAL: begin
          wr = (inst[31:26] == OP_JAL);
          taken = 1'b1;
          // region bits come from the delay slot address
          tgt = pc + 4;
          tgt = {tgt[31:28], inst[25:0], 2'b00};
          d = LINK_REG;
          v = pc + 8;
        end
        default: wr = 1'b0;
      endcase
      if (wr && d != '0) begin
        r[d] = v;
        exp_pc.push_back(pc);
        exp_num.push_back(d);
        exp_data.push_back(v);
      end
      pc = npc;
      npc = taken ? tgt : npc + 4;
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    arst_n_i = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    got_pc.delete();
    got_num.delete();
    got_data.delete();
    got_st_addr.delete();
    got_st_wen.delete();
    got_st_data.delete();
    check_word("inst_sram_en_o", {31'd0, inst_en}, 32'd1);
    check_word("inst_sram_addr_o", inst_addr, RESET_PC);
    check_word("data_sram_en_o", {31'd0, data_en}, '0);
    check_wen("data_sram_wen_o", data_wen, '0);
    check_wen("debug_wb_rf_wen_o", dbg_wen, '0);
    arst_n_i = 1'b1;
  endtask

  task automatic run_and_check(input string name);
    int start_errors, n;
    start_errors = errors;
    // marker write retires last, after every store
    prog.push_back(encode_i(OP_ORI, 0, 30, 16'h77));
    i_inst_mem.fill(1'b0);
    i_data_mem.fill(1'b1);
    foreach (prog[i]) i_inst_mem.load_word(RESET_PC + 4 * i, prog[i]);
    build_expected();
    apply_reset();
    n = 0;
    while (got_pc.size() < exp_pc.size() && n < TEST_CYCLES) begin
      @(posedge clk);
      n++;
    end
    repeat (3) @(posedge clk);
    if (got_pc.size() < exp_pc.size()) begin
      $display("%s: expected write never retired (%0d of %0d)",
               name, got_pc.size(), exp_pc.size());
      errors++;
    end else if (got_pc.size() > exp_pc.size()) begin
      $display("%s: more writes retired than the program holds", name);
      errors++;
    end
    for (int i = 0; i < exp_pc.size() && i < got_pc.size(); i++) begin
      check_word("debug_wb_pc_o", got_pc[i], exp_pc[i]);
      check_reg("debug_wb_rf_wnum_o", got_num[i], exp_num[i]);
      check_word("debug_wb_rf_wdata_o", got_data[i], exp_data[i]);
    end
    if (got_st_addr.size() != exp_st_addr.size()) begin
      $display("%s: %0d stores seen on the data bus, %0d expected",
               name, got_st_addr.size(), exp_st_addr.size());
      errors++;
    end
    for (int i = 0; i < exp_st_addr.size() && i < got_st_addr.size(); i++) begin
      check_word("data_sram_addr_o", got_st_addr[i], exp_st_addr[i]);
      check_wen("data_sram_wen_o", got_st_wen[i], exp_st_wen[i]);
      check_word("data_sram_wdata_o", got_st_data[i], exp_st_data[i]);
    end
    foreach (ref_mem[a]) check_word("data memory word", i_data_mem.peek(a), ref_mem[a]);
    tests++;
    if (errors != start_errors) failing++;
    $display("%s%s: %s", name, stall_on ? " with stalls" : "",
             (errors == start_errors) ? "passed" : "FAILED");
    prog.delete();
  endtask

  task automatic alu_ops_test();
    prog = '{encode_i(OP_ADDIU, 0, 1, -5), encode_i(OP_ADDIU, 0, 2, 7),
             encode_i(OP_LUI, 0, 3, 16'h8000), encode_i(OP_ORI, 3, 3, 16'h1234),
             encode_i(OP_ANDI, 1, 4, 16'hff0f), encode_r(FN_ADDU, 1, 2, 5, 0),
             encode_r(FN_SUBU, 2, 1, 6, 0), encode_r(FN_AND, 1, 3, 7, 0),
             encode_r(FN_OR, 1, 2, 8, 0), encode_r(FN_XOR, 3, 1, 9, 0),
             encode_r(FN_SLT, 1, 2, 10, 0), encode_r(FN_SLTU, 1, 2, 11, 0),
             encode_r(FN_SLT, 3, 1, 12, 0), encode_r(FN_SLL, 0, 2, 13, 4),
             encode_i(OP_ADDIU, 0, 0, 9)};
    run_and_check("alu_ops");
  endtask

  task automatic forwarding_test();
    prog = '{encode_i(OP_ADDIU, 0, 1, 3), encode_r(FN_ADDU, 1, 1, 2, 0),
             encode_r(FN_ADDU, 2, 1, 3, 0), encode_r(FN_ADDU, 3, 1, 4, 0),
             encode_r(FN_SUBU, 4, 2, 5, 0), encode_r(FN_XOR, 5, 3, 6, 0),
             encode_r(FN_SLL, 0, 6, 7, 3), encode_r(FN_OR, 7, 5, 8, 0),
             encode_i(OP_ADDIU, 8, 8, -100), encode_r(FN_SLT, 8, 7, 9, 0)};
    run_and_check("forwarding");
  endtask

  task automatic load_store_test();
    prog = '{encode_i(OP_ADDIU, 0, 1, 16'h40), encode_i(OP_LUI, 0, 2, 16'h8765),
             encode_i(OP_ORI, 2, 2, 16'h43a1), encode_i(OP_SW, 1, 2, 0),
             encode_i(OP_SB, 1, 2, 5), encode_i(OP_SB, 1, 1, 6),
             encode_i(OP_SB, 1, 2, 11), encode_i(OP_LW, 1, 3, 0),
             encode_i(OP_LB, 1, 4, 3), encode_i(OP_LBU, 1, 5, 3),
             encode_i(OP_LB, 1, 6, 0), encode_i(OP_LW, 1, 7, 4),
             encode_i(OP_LBU, 1, 8, 6), encode_i(OP_LB, 1, 9, 1)};
    run_and_check("load_store");
  endtask

  task automatic load_use_test();
    prog = '{encode_i(OP_ADDIU, 0, 1, 16'h80), encode_i(OP_ADDIU, 0, 2, 16'h1234),
             encode_i(OP_SW, 1, 2, 0), encode_i(OP_LW, 1, 3, 0),
             encode_r(FN_ADDU, 3, 3, 4, 0), encode_i(OP_LW, 1, 5, 4),
             encode_i(OP_ADDIU, 0, 6, 1), encode_r(FN_ADDU, 5, 6, 7, 0),
             encode_i(OP_SW, 1, 7, 8), encode_i(OP_LW, 1, 8, 8),
             encode_i(OP_BNE, 8, 7, 2), encode_i(OP_ADDIU, 0, 9, 9),
             encode_i(OP_ADDIU, 0, 10, 10), encode_i(OP_LB, 1, 11, 1),
             encode_i(OP_SB, 1, 11, 13), encode_i(OP_LW, 1, 12, 12)};
    run_and_check("load_use");
  endtask

  task automatic branch_test();
    prog = '{encode_i(OP_ADDIU, 0, 1, 1), encode_i(OP_ADDIU, 0, 2, 1),
             encode_i(OP_BEQ, 1, 2, 2), encode_i(OP_ADDIU, 0, 3, 3),
             encode_i(OP_ADDIU, 0, 4, 4), encode_i(OP_BNE, 1, 2, 2),
             encode_i(OP_ADDIU, 0, 5, 5), encode_i(OP_ADDIU, 0, 6, 6),
             encode_j(OP_J, 11), encode_i(OP_ADDIU, 0, 7, 7),
             encode_i(OP_ADDIU, 0, 8, 8), encode_j(OP_JAL, 14),
             encode_i(OP_ADDIU, 0, 9, 9), encode_i(OP_ADDIU, 0, 10, 10),
             encode_r(FN_ADDU, 31, 0, 11, 0), encode_i(OP_BNE, 1, 0, 2),
             encode_i(OP_ADDIU, 0, 12, 12), encode_i(OP_ADDIU, 0, 13, 13),
             encode_i(OP_BEQ, 1, 0, 1), encode_i(OP_ADDIU, 0, 14, 14)};
    run_and_check("branch");
  endtask

  initial begin
    arst_n_i = 1'b0;
    bus_stall_i = 1'b0;
    stall_on = 1'b0;
    errors = 0;
    tests = 0;
    failing = 0;
    cycles = 0;
    void'($urandom(32'hc65b29d6));
    alu_ops_test();
    forwarding_test();
    load_store_test();
    load_use_test();
    branch_test();
    stall_on = 1'b1;
    forwarding_test();
    load_store_test();
    load_use_test();
    branch_test();
    $display("tests run %0d, failing %0d, errors %0d", tests, failing, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- files.f
hw/cpu_pkg.sv
hw/fetch_unit.sv
hw/decoder.sv
hw/regfile.sv
hw/execute.sv
hw/mem_access.sv
hw/cpu_core.sv
verif/tb_sram_model.sv
verif/tb_cpu_core.sv
